/* bench/int_div_vectors.svh */
// directed vectors for the iterative divider, request and expected response per row
// unsigned, signed sign combinations, divide by zero and signed overflow

`ifndef int_div_vectors_svh
`define int_div_vectors_svh

// one row of the table
typedef struct packed {
  int_div_pkg::div_req_msg_t  req;
  int_div_pkg::div_resp_msg_t exp;
} vector_t;

localparam int table_size = 19;

// short names keep the rows readable
localparam int_div_pkg::div_fn_t fn_u = int_div_pkg::div_unsigned;
localparam int_div_pkg::div_fn_t fn_s = int_div_pkg::div_signed;

vector_t vector_table [$];

// append one row, expected values worked out by hand
task automatic add_vector(input int_div_pkg::div_fn_t fn, input int_div_pkg::word_t a,
                          input int_div_pkg::word_t b, input int_div_pkg::word_t quot,
                          input int_div_pkg::word_t rem);
  vector_t row;
  row.req.fn   = fn;
  row.req.a    = a;
  row.req.b    = b;
  row.exp.quot = quot;
  row.exp.rem  = rem;
  vector_table.push_back(row);
endtask

task automatic load_vector_table();
  // columns: fn, dividend, divisor, quotient, remainder
  // unsigned, top bit set on some operands
  add_vector(fn_u, 32'h0000_0064, 32'h0000_0007, 32'h0000_000e, 32'h0000_0002);
  add_vector(fn_u, 32'hffff_ffff, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0000);
  add_vector(fn_u, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);
  add_vector(fn_u, 32'h8000_0000, 32'h0000_0003, 32'h2aaa_aaaa, 32'h0000_0002);
  add_vector(fn_u, 32'h0000_0005, 32'h0000_000a, 32'h0000_0000, 32'h0000_0005);
  add_vector(fn_u, 32'hdead_beef, 32'h0000_0010, 32'h0dea_dbee, 32'h0000_000f);
  add_vector(fn_u, 32'h1234_5678, 32'h0000_1000, 32'h0001_2345, 32'h0000_0678);
  add_vector(fn_u, 32'h0000_0000, 32'h0000_0005, 32'h0000_0000, 32'h0000_0000);
  // signed, all four sign combinations of 100 and 7
  add_vector(fn_s, 32'h0000_0064, 32'h0000_0007, 32'h0000_000e, 32'h0000_0002);
  add_vector(fn_s, 32'hffff_ff9c, 32'h0000_0007, 32'hffff_fff2, 32'hffff_fffe);
  add_vector(fn_s, 32'h0000_0064, 32'hffff_fff9, 32'hffff_fff2, 32'h0000_0002);
  add_vector(fn_s, 32'hffff_ff9c, 32'hffff_fff9, 32'h0000_000e, 32'hffff_fffe);
  // most negative number, overflow case and small remainders
  add_vector(fn_s, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_0000);
  add_vector(fn_s, 32'h8000_0000, 32'h0000_0001, 32'h8000_0000, 32'h0000_0000);
  add_vector(fn_s, 32'hffff_ffff, 32'h0000_0002, 32'h0000_0000, 32'hffff_ffff);
  add_vector(fn_s, 32'h7fff_ffff, 32'h8000_0000, 32'h0000_0000, 32'h7fff_ffff);
  // divide by zero gives all ones and the dividend
  add_vector(fn_u, 32'h1234_5678, 32'h0000_0000, 32'hffff_ffff, 32'h1234_5678);
  add_vector(fn_s, 32'hffff_fffb, 32'h0000_0000, 32'hffff_ffff, 32'hffff_fffb);
  add_vector(fn_s, 32'h0000_0007, 32'h0000_0000, 32'hffff_ffff, 32'h0000_0007);
endtask

`endif

/* bench/int_div_tb.sv */
// testbench for the iterative integer divider
// directed table, seeded random vectors under response stalls, latency and handshake checks

`timescale 1ns/10ps

module int_div_tb;

  `include "int_div_vectors.svh"

  // ------------------------------
  // run limits
  // ------------------------------

  localparam int reset_cycles = 16;
  localparam int random_count = 40;
  localparam int max_stall    = 5;
  // acceptance edge plus one edge per quotient bit
  localparam int expected_latency = 33;
  // latency, worst stall and handshake overhead per vector
  localparam int cycles_per_vector = 33 + 5 + 4;
  localparam int watchdog_ns =
    (reset_cycles + (table_size + random_count) * cycles_per_vector) * 100;

  logic                       clk;
  logic                       reset;
  int_div_pkg::div_req_msg_t  req_msg;
  logic                       req_val;
  logic                       req_rdy;
  int_div_pkg::div_resp_msg_t resp_msg;
  logic                       resp_val;
  logic                       resp_rdy;

  integer seed;
  int     error_count;
  int     pass_count;
  int     fail_count;

  int_div_iterative int_div_iterative_inst (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic compare_resp(input string name, input int_div_pkg::div_resp_msg_t got,
                              input int_div_pkg::div_resp_msg_t exp);
    if (got.quot !== exp.quot) begin
      $display("ERROR %s quot: got %h expected %h", name, got.quot, exp.quot);
      error_count++;
    end
    if (got.rem !== exp.rem) begin
      $display("ERROR %s rem: got %h expected %h", name, got.rem, exp.rem);
      error_count++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_latency(input string name, input int_div_pkg::word_t got,
                                 input int_div_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // expected response from the division rules, worked on magnitudes
  function automatic int_div_pkg::div_resp_msg_t model_div(
    input int_div_pkg::div_req_msg_t req
  );
    logic                       a_neg;
    logic                       b_neg;
    int_div_pkg::word_t         a_mag;
    int_div_pkg::word_t         b_mag;
    int_div_pkg::div_resp_msg_t resp;
    a_neg = (req.fn == int_div_pkg::div_signed) && req.a[31];
    b_neg = (req.fn == int_div_pkg::div_signed) && req.b[31];
    a_mag = a_neg ? -req.a : req.a;
    b_mag = b_neg ? -req.b : req.b;
    if (req.b == '0) begin
      resp.quot = '1;
      resp.rem  = req.a;
    end else begin
      resp.quot = (a_neg ^ b_neg) ? -(a_mag / b_mag) : (a_mag / b_mag);
      // remainder follows the dividend
      resp.rem  = a_neg ? -(a_mag % b_mag) : (a_mag % b_mag);
    end
    return resp;
  endfunction

  // one line per finished test
  task automatic report_test(input int idx, input string label, input int errors_before);
    if (error_count == errors_before) begin
      pass_count++;
      $display("test %0d %s: ok", idx, label);
    end else begin
      fail_count++;
      $display("test %0d %s: %0d mismatches", idx, label, error_count - errors_before);
    end
  endtask

  // ------------------------------
  // one division through the handshake
  // ------------------------------

  task automatic run_vector(input int idx, input string kind,
                            input int_div_pkg::div_req_msg_t req,
                            input int_div_pkg::div_resp_msg_t exp);
    int                         errors_before;
    int                         stall;
    int_div_pkg::word_t         latency;
    int_div_pkg::div_resp_msg_t held;
    errors_before = error_count;
    stall = {$random(seed)} % (max_stall + 1);
    @(negedge clk);
    req_msg = req;
    req_val = 1'b1;
    while (!req_rdy) begin
      @(negedge clk);
    end
    // next rising edge accepts, count it as the first edge
    @(negedge clk);
    req_val = 1'b0;
    latency = 1;
    while (!resp_val && latency <= int_div_pkg::word_t'(expected_latency)) begin
      compare_bit("req_rdy", req_rdy, 1'b0);
      @(negedge clk);
      latency = latency + 1;
    end
    if (!resp_val) begin
      $display("no response within %0d edges of acceptance", expected_latency);
      error_count++;
    end else begin
      compare_latency("resp latency", latency, int_div_pkg::word_t'(expected_latency));
      held = resp_msg;
      // back-pressure, result and valid must hold
      repeat (stall) begin
        @(negedge clk);
        compare_bit("resp_val", resp_val, 1'b1);
        compare_bit("req_rdy", req_rdy, 1'b0);
        compare_resp("resp_msg held", resp_msg, held);
      end
      compare_resp("resp_msg", resp_msg, exp);
      resp_rdy = 1'b1;
      @(negedge clk);
      resp_rdy = 1'b0;
      // response taken, back to idle
      compare_bit("resp_val", resp_val, 1'b0);
      compare_bit("req_rdy", req_rdy, 1'b1);
    end
    report_test(idx, $sformatf("%s fn=%0d a=%h b=%h stall=%0d", kind, req.fn, req.a, req.b,
                               stall), errors_before);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    int_div_pkg::div_req_msg_t rand_req;
    int_div_pkg::word_t        rand_bits;
    int                        shift;
    int                        errors_before;
    seed        = 8234;
    clk         = 1'b0;
    reset       = 1'b1;
    req_msg     = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b0;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    load_vector_table();
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;

    // idle levels straight after reset
    errors_before = error_count;
    compare_bit("req_rdy", req_rdy, 1'b1);
    compare_bit("resp_val", resp_val, 1'b0);
    report_test(0, "reset levels", errors_before);

    foreach (vector_table[i]) begin
      run_vector(i + 1, "table", vector_table[i].req, vector_table[i].exp);
    end

    for (int n = 0; n < random_count; n++) begin
      rand_bits   = $random(seed);
      rand_req.fn = int_div_pkg::div_fn_t'(rand_bits[0]);
      rand_req.a  = $random(seed);
      rand_bits   = $random(seed);
      shift       = {$random(seed)} % 32;
      // shorter divisors give wider quotients, a full shift may give zero
      rand_req.b  = rand_bits >> shift;
      run_vector(table_size + n + 1, "random", rand_req, model_div(rand_req));
    end

    $display("summary: %0d tests ok, %0d tests with mismatches, %0d check errors",
             pass_count, fail_count, error_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog sized from the vector count
  initial begin
    #(watchdog_ns);
    $display("timeout: run still going after %0d ns", watchdog_ns);
    $display("Regression failed");
    $finish;
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the iterative divider testbench with Verilator.
# The exit status is non-zero when the build fails, the run fails,
# or the log reports a failing regression.

cd "$(dirname "$0")" || exit 1

log_file=sim.log
obj_dir=obj_dir

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f verilog.f --top-module int_div_tb -Mdir "$obj_dir" -o int_div_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$obj_dir/int_div_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" "$log_file"; then
  echo "failures found in $log_file"
  exit 1
fi

echo "no failures found in $log_file"
exit 0

/* source/int_div_ctrl.sv */
// control FSM of the iterative divider
// idle/calc/done sequencing, calc counter, handshake and datapath enables

`timescale 1ns/10ps

module int_div_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  output logic                    req_rdy,
  output logic                    resp_val,
  input  logic                    resp_rdy,
  output int_div_pkg::div_ctrl_t  ctrl
);

  int_div_pkg::div_state_t state;
  int_div_pkg::count_t     count;

  logic req_go;
  logic resp_go;
  logic last_step;

  // transfers on either side
  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  // final quotient bit this cycle
  assign last_step = (count == int_div_pkg::count_t'(int_div_pkg::iter_count - 1));

  // ------------------------------
  // state and counter
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= int_div_pkg::st_idle;
      count <= '0;
    end else begin
      case (state)
        int_div_pkg::st_idle: begin
          if (req_go) begin
            state <= int_div_pkg::st_calc;
            count <= '0;
          end
        end
        int_div_pkg::st_calc: begin
          if (last_step) begin
            state <= int_div_pkg::st_done;
          end else begin
            count <= count + int_div_pkg::count_t'(1);
          end
        end
        int_div_pkg::st_done: begin
          // hold the result until the consumer takes it
          if (resp_go) begin
            state <= int_div_pkg::st_idle;
            count <= '0;
          end
        end
        default: begin
          state <= int_div_pkg::st_idle;
        end
      endcase
    end
  end

  // ------------------------------
  // outputs
  // ------------------------------

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    ctrl     = '0;
    case (state)
      int_div_pkg::st_idle: begin
        req_rdy   = 1'b1;
        // load operands on the accept edge
        ctrl.a_en = req_go;
        ctrl.b_en = req_go;
      end
      int_div_pkg::st_calc: begin
        // accumulator takes the shift-subtract result
        ctrl.a_en      = 1'b1;
        ctrl.a_mux_sel = 1'b1;
      end
      int_div_pkg::st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  // ------------------------------
  // checks
  // ------------------------------

  // one division in flight at a time
  assert property (@(posedge clk) disable iff (reset) !(resp_val && req_rdy))
    else $error("ctrl: resp_val and req_rdy high together");

  // a response only follows a full run of calc cycles
  assert property (
    @(posedge clk) disable iff (reset)
    $rose(resp_val) |-> $past(state == int_div_pkg::st_calc && last_step) &&
                        $past(state == int_div_pkg::st_calc && count == '0,
                              int_div_pkg::iter_count)
  ) else $error("ctrl: resp_val rose without %0d calc cycles", int_div_pkg::iter_count);

  // valid is held under back-pressure
  assert property (@(posedge clk) disable iff (reset) resp_val && !resp_rdy |=> resp_val)
    else $error("ctrl: resp_val dropped before resp_rdy");

endmodule

/* source/int_div_dpath.sv */
// datapath of the iterative divider
// restoring shift-subtract over a 65-bit accumulator, with sign fix-up on the way out

`timescale 1ns/10ps

module int_div_dpath (
  input  logic                        clk,
  input  logic                        reset,
  input  int_div_pkg::div_req_msg_t   req_msg,
  input  int_div_pkg::div_ctrl_t      ctrl,
  output int_div_pkg::div_resp_msg_t  resp_msg
);

  // two's complement negate when the flag is set
  function automatic int_div_pkg::word_t negate_if(
    input logic                neg,
    input int_div_pkg::word_t  value
  );
    int_div_pkg::word_t negated;
    negated = ~value + int_div_pkg::word_t'(1);
    return neg ? negated : value;
  endfunction

  // ------------------------------
  // operand magnitudes at load
  // ------------------------------

  logic               req_signed;
  logic               a_sign_in;
  logic               b_sign_in;
  int_div_pkg::word_t a_mag;
  int_div_pkg::word_t b_mag;

  assign req_signed = (req_msg.fn == int_div_pkg::div_signed);

  // sign bits only count for signed division
  assign a_sign_in = req_signed & req_msg.a[int_div_pkg::word_bits-1];
  assign b_sign_in = req_signed & req_msg.b[int_div_pkg::word_bits-1];

  assign a_mag = negate_if(a_sign_in, req_msg.a);
  assign b_mag = negate_if(b_sign_in, req_msg.b);

  // dividend sits in the quotient half, upper half starts empty
  int_div_pkg::acc_t  a_init;
  // divisor lines up with the remainder half
  int_div_pkg::acc_t  b_init;

  assign a_init = {1'b0, int_div_pkg::word_t'(0), a_mag};
  assign b_init = {1'b0, b_mag, int_div_pkg::word_t'(0)};

  // ------------------------------
  // registers
  // ------------------------------

  int_div_pkg::acc_t    a_reg;
  int_div_pkg::acc_t    b_reg;
  int_div_pkg::div_fn_t fn_reg;
  logic                 a_sign_reg;
  logic                 b_sign_reg;
  logic                 b_zero_reg;

  // ------------------------------
  // one restoring step
  // ------------------------------

  int_div_pkg::acc_t  a_shift;
  int_div_pkg::acc_t  sub_out;
  int_div_pkg::acc_t  a_step;
  logic               sub_neg;

  assign a_shift = a_reg << 1;
  assign sub_out = a_shift - b_reg;

  // guard bit set means the shifted remainder was smaller than the divisor
  assign sub_neg = sub_out[2*int_div_pkg::word_bits];

  always_comb begin
    if (sub_neg) begin
      // restore, quotient bit stays zero from the shift
      a_step = a_shift;
    end else begin
      // keep the difference and set the new quotient bit
      a_step = {sub_out[2*int_div_pkg::word_bits:1], 1'b1};
    end
  end

  // accumulator: load on accept, step during calc
  always_ff @(posedge clk) begin
    if (ctrl.a_en) begin
      a_reg <= ctrl.a_mux_sel ? a_step : a_init;
    end
  end

  // divisor and result flags only change at accept
  always_ff @(posedge clk) begin
    if (ctrl.b_en) begin
      b_reg      <= b_init;
      fn_reg     <= req_msg.fn;
      // raw operand signs, qualified by fn at the output
      a_sign_reg <= req_msg.a[int_div_pkg::word_bits-1];
      b_sign_reg <= req_msg.b[int_div_pkg::word_bits-1];
      b_zero_reg <= (req_msg.b == int_div_pkg::word_t'(0));
    end
  end

  // ------------------------------
  // sign fix-up of the result
  // ------------------------------

  logic               quot_neg;
  logic               rem_neg;
  int_div_pkg::word_t quot_mag;
  int_div_pkg::word_t rem_mag;

  // quotient negative when exactly one operand was negative
  // divide by zero keeps the all-ones quotient
  assign quot_neg = (fn_reg == int_div_pkg::div_signed) & (a_sign_reg ^ b_sign_reg) &
                    ~b_zero_reg;

  // remainder follows the dividend
  assign rem_neg = (fn_reg == int_div_pkg::div_signed) & a_sign_reg;

  assign quot_mag = a_reg[int_div_pkg::word_bits-1:0];
  assign rem_mag  = a_reg[2*int_div_pkg::word_bits-1:int_div_pkg::word_bits];

  assign resp_msg.quot = negate_if(quot_neg, quot_mag);
  assign resp_msg.rem  = negate_if(rem_neg, rem_mag);

  // ------------------------------
  // checks
  // ------------------------------

  // remainder never outgrows the divisor, so the guard bit clears after each step
  assert property (
    @(posedge clk) disable iff (reset)
    $past(ctrl.a_en && ctrl.a_mux_sel) |-> !a_reg[2*int_div_pkg::word_bits]
  ) else $error("dpath: accumulator guard bit set after calc step");

endmodule

/* source/int_div_iterative.sv */
// iterative 32-bit integer divider, one quotient bit per cycle
// joins the control FSM and the restoring datapath

`timescale 1ns/10ps

module int_div_iterative (
  input  logic                        clk,
  input  logic                        reset,

  // request side
  input  int_div_pkg::div_req_msg_t   req_msg,
  input  logic                        req_val,
  output logic                        req_rdy,

  // response side
  output int_div_pkg::div_resp_msg_t  resp_msg,
  output logic                        resp_val,
  input  logic                        resp_rdy
);

  // ------------------------------
  // control to datapath
  // ------------------------------

  // enables and accumulator select, no status comes back
  int_div_pkg::div_ctrl_t ctrl_bus;

  // ------------------------------
  // control
  // ------------------------------

  // owns the handshake and the calc count
  int_div_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctrl     (ctrl_bus)
  );

  // ------------------------------
  // datapath
  // ------------------------------

  // owns the operands and forms the signed result
  int_div_dpath dpath (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .ctrl     (ctrl_bus),
    .resp_msg (resp_msg)
  );

endmodule

/* source/int_div_pkg.sv */
// shared types and constants for the iterative integer divider
// widths, message structs, control bundle and FSM encoding

package int_div_pkg;

  // ------------------------------
  // widths and iteration count
  // ------------------------------

  // operand width
  localparam int word_bits = 32;
  // one calc cycle per quotient bit
  localparam int iter_count = word_bits;

  // operand, quotient and remainder
  typedef logic [word_bits-1:0] word_t;
  // guard bit + remainder half + quotient half
  typedef logic [2*word_bits:0] acc_t;
  // calc cycle counter
  typedef logic [$clog2(iter_count)-1:0] count_t;

  // ------------------------------
  // messages and control
  // ------------------------------

  typedef enum logic {div_unsigned, div_signed} div_fn_t;

  // request {fn, a, b}, 65 bits
  typedef struct packed {div_fn_t fn; word_t a; word_t b;} div_req_msg_t;

  // response {rem, quot}, 64 bits
  typedef struct packed {word_t rem; word_t quot;} div_resp_msg_t;

  // control to datapath enables and select
  typedef struct packed {logic a_en; logic b_en; logic a_mux_sel;} div_ctrl_t;

  // control FSM
  typedef enum logic [1:0] {st_idle, st_calc, st_done} div_state_t;

endpackage

/* verilog.f */
+incdir+bench
source/int_div_pkg.sv
source/int_div_ctrl.sv
source/int_div_dpath.sv
source/int_div_iterative.sv
bench/int_div_tb.sv
